//--- include/prbs_defs.svh
// PRBS31 settings shared by all blocks; the polynomial omits its x^31 term and the seed must not be zero
`ifndef PRBS_DEFS_SVH
`define PRBS_DEFS_SVH

// shift register length
`define PRBS_LFSR_W 31

// x^31 + x^28 + 1 with the top term implied
// bit k taps the bit emitted k steps earlier, bit 0 is the constant term
`define PRBS_POLY 31'h10000001

// reset state of the generator
// all ones, any nonzero value would do
`define PRBS_SEED {`PRBS_LFSR_W{1'b1}}

// bits per word, first emitted bit in the msb
`define PRBS_DATA_W 8

// saturating bit error counter width
`define PRBS_CNT_W 16

// consecutive bad words that drop lock
`define PRBS_UNLOCK_N 4

`endif

//--- hw/prbs_pkg.sv
// types for the PRBS loopback blocks; word and counter widths come from the shared macro header
`default_nettype none

`include "prbs_defs.svh"

package prbs_pkg;

    // one parallel word of the stream
    // msb is the first bit on the line
    typedef logic [`PRBS_DATA_W-1:0] prbs_word_t;

    // checker sync state
    typedef enum logic {
        // collecting bits to seed the local lfsr
        CHK_HUNT = 1'b0,
        // predicting and comparing every word
        CHK_LOCK = 1'b1
    } chk_state_t;

    // checker report
    typedef struct packed {
        // checker is in sync with the stream
        logic                   locked;
        // one cycle pulse for a locked word with errors
        logic                   bit_err;
        // total bit errors, sticks at all ones
        logic [`PRBS_CNT_W-1:0] err_count;
    } prbs_status_t;

endpackage

`default_nettype wire

//--- hw/lfsr_core.sv
// purely combinational Fibonacci only; LFSR_POLY omits the x^LFSR_W term and its bit 0 has no tap
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module lfsr_core #(
    // register length
    parameter int                LFSR_W    = `PRBS_LFSR_W,
    // feedback taps, top term implied
    parameter logic [LFSR_W-1:0] LFSR_POLY = `PRBS_POLY,
    // bit steps per call
    parameter int                DATA_W    = `PRBS_DATA_W
) (
    input  wire logic [LFSR_W-1:0] state_in,
    output wire logic [LFSR_W-1:0] state_out,
    output wire logic [DATA_W-1:0] data_out
);

    // state after each unrolled step
    // stage 0 is the input, stage DATA_W the result
    logic [LFSR_W-1:0] stage [0:DATA_W];

    // feedback bit of each step
    // this is also the emitted bit
    logic [DATA_W-1:0] fb;

    // taps below the top bit
    // poly bit k reads state bit k-1, the bit emitted k steps back
    localparam logic [LFSR_W-2:0] TAP_MASK = LFSR_POLY[LFSR_W-1:1];

    assign stage[0] = state_in;

    // one fibonacci shift per generated block
    for (genvar i = 0; i < DATA_W; i++) begin : g_step
        // oldest bit always feeds back
        // the x^LFSR_W term of the polynomial
        assign fb[i] = stage[i][LFSR_W-1] ^ (^(stage[i][LFSR_W-2:0] & TAP_MASK));

        // newest bit enters at bit 0
        // so bit j holds the bit emitted j+1 steps ago
        assign stage[i+1] = {stage[i][LFSR_W-2:0], fb[i]};

        // first step lands in the msb
        assign data_out[DATA_W-1-i] = fb[i];
    end

    // state after all DATA_W steps
    // equals the last LFSR_W emitted bits when DATA_W >= LFSR_W
    assign state_out = stage[DATA_W];

endmodule

`default_nettype wire

//--- hw/prbs_gen.sv
// one word per enabled cycle, output registered once; inject_err is only looked at while enable is high
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_gen
    import prbs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       enable,
    input  wire logic       inject_err,
    output prbs_word_t      tx_word,
    output logic            tx_valid
);

    // running prbs31 state
    logic [`PRBS_LFSR_W-1:0] state_q;
    logic [`PRBS_LFSR_W-1:0] state_next;

    // raw bits of the next word, not yet inverted
    prbs_word_t gen_bits;

    // bit 0 flip mask for error injection
    prbs_word_t err_mask;

    lfsr_core #(
        .LFSR_W   (`PRBS_LFSR_W),
        .LFSR_POLY(`PRBS_POLY),
        .DATA_W   (`PRBS_DATA_W)
    ) lfsr_core_inst (
        .state_in (state_q),
        .state_out(state_next),
        .data_out (gen_bits)
    );

    assign err_mask = {{(`PRBS_DATA_W-1){1'b0}}, inject_err};

    // state only moves on enable
    // gaps hold the sequence where it is
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= `PRBS_SEED;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= enable;
            if (enable) begin
                state_q <= state_next;
            end
        end
    end

    // inverted prbs31 output word
    always_ff @(posedge clk) begin
        if (enable) begin
            tx_word <= ~gen_bits ^ err_mask;
        end
    end

    // a word goes out exactly one cycle after the sequence moved on
    // an 8 step advance never returns the same state
    a_valid_follows_enable: assert property (
        @(posedge clk) disable iff (rst)
        $past(!rst) |-> (tx_valid == (state_q != $past(state_q)))
    );

endmodule

`default_nettype wire

//--- hw/prbs_check.sv
// needs an inverted PRBS31 stream msb first; status lags rx_valid by one cycle, no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_check
    import prbs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire prbs_word_t rx_word,
    input  wire logic       rx_valid,
    output prbs_status_t    status
);

    // hunt history length and the words needed to fill it
    localparam int HIST_W = 32;
    localparam int HUNT_N = HIST_W / `PRBS_DATA_W;
    localparam int HCNT_W = $clog2(HUNT_N);
    // popcount width for one word
    localparam int ERR_W  = $clog2(`PRBS_DATA_W + 1);
    // bad word run counter width
    localparam int RUN_W  = $clog2(`PRBS_UNLOCK_N + 1);

    chk_state_t              chk_state;
    logic [HCNT_W-1:0]       hunt_cnt;
    logic [RUN_W-1:0]        bad_run;
    logic                    bit_err_q;
    logic [`PRBS_CNT_W-1:0]  err_count_q;

    // received bits as history, newest bit at bit 0
    logic [HIST_W-1:0]       history;
    logic [HIST_W-1:0]       hist_next;

    // local copy of the transmitter lfsr
    logic [`PRBS_LFSR_W-1:0] lfsr_state;
    logic [`PRBS_LFSR_W-1:0] pred_state;
    prbs_word_t              pred_bits;

    prbs_word_t              rx_plain;
    prbs_word_t              mismatch;
    logic                    bad_word;
    logic [ERR_W-1:0]        err_bits;
    logic [`PRBS_CNT_W:0]    cnt_sum;
    logic [`PRBS_CNT_W-1:0]  cnt_sat;
    logic                    hunt_done;
    logic                    unlock;

    lfsr_core #(
        .LFSR_W   (`PRBS_LFSR_W),
        .LFSR_POLY(`PRBS_POLY),
        .DATA_W   (`PRBS_DATA_W)
    ) lfsr_core_inst (
        .state_in (lfsr_state),
        .state_out(pred_state),
        .data_out (pred_bits)
    );

    // undo the line inversion
    assign rx_plain  = ~rx_word;
    assign hist_next = {history[HIST_W-`PRBS_DATA_W-1:0], rx_plain};

    assign mismatch = rx_plain ^ pred_bits;
    assign bad_word = |mismatch;

    // count differing bits
    always_comb begin
        err_bits = '0;
        for (int i = 0; i < `PRBS_DATA_W; i++) begin
            err_bits = err_bits + ERR_W'(mismatch[i]);
        end
    end

    // add with one spare bit, clamp on carry
    assign cnt_sum = {1'b0, err_count_q} + {{(`PRBS_CNT_W+1-ERR_W){1'b0}}, err_bits};
    assign cnt_sat = cnt_sum[`PRBS_CNT_W] ? '1 : cnt_sum[`PRBS_CNT_W-1:0];

    assign hunt_done = (hunt_cnt == HCNT_W'(HUNT_N - 1));
    assign unlock    = bad_word && (bad_run == RUN_W'(`PRBS_UNLOCK_N - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            chk_state   <= CHK_HUNT;
            hunt_cnt    <= '0;
            bad_run     <= '0;
            bit_err_q   <= 1'b0;
            err_count_q <= '0;
        end else begin
            bit_err_q <= 1'b0;
            if (rx_valid) begin
                case (chk_state)
                    CHK_HUNT: begin
                        hunt_cnt <= hunt_cnt + 1'b1;
                        if (hunt_done) begin
                            chk_state <= CHK_LOCK;
                            hunt_cnt  <= '0;
                            bad_run   <= '0;
                        end
                    end
                    CHK_LOCK: begin
                        err_count_q <= cnt_sat;
                        if (!bad_word) begin
                            bad_run <= '0;
                        end else if (unlock) begin
                            // last bad word still counts
                            // no pulse since status already shows unlocked
                            chk_state <= CHK_HUNT;
                            bad_run   <= '0;
                        end else begin
                            bit_err_q <= 1'b1;
                            bad_run   <= bad_run + 1'b1;
                        end
                    end
                    default: chk_state <= CHK_HUNT;
                endcase
            end
        end
    end

    // history always shifts in hunt
    // 31 newest bits become the lfsr state when full
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (chk_state == CHK_HUNT) begin
                history <= hist_next;
                if (hunt_done) begin
                    lfsr_state <= hist_next[`PRBS_LFSR_W-1:0];
                end
            end else begin
                // advance from the prediction, not the received bits
                lfsr_state <= pred_state;
            end
        end
    end

    assign status = '{
        locked:    (chk_state == CHK_LOCK),
        bit_err:   bit_err_q,
        err_count: err_count_q
    };

    // counter only grows between resets
    a_count_monotonic: assert property (
        @(posedge clk) disable iff (rst)
        $past(!rst) |-> (status.err_count >= $past(status.err_count))
    );

    // error pulses only ever come from a locked word
    a_err_needs_lock: assert property (
        @(posedge clk) disable iff (rst)
        status.bit_err |-> status.locked
    );

endmodule

`default_nettype wire

//--- hw/prbs_loopback.sv
// generator wired straight into the checker; no channel model, the sent words are also brought out
`timescale 1ns/1ps
`default_nettype none

module prbs_loopback
    import prbs_pkg::*;
(
    // shared clock and synchronous reset
    input  wire logic       clk,
    input  wire logic       rst,

    // one word per cycle while high
    input  wire logic       enable,
    // flip bit 0 of the word made this cycle
    input  wire logic       inject_err,

    // sent stream, visible for checking
    output prbs_word_t      tx_word,
    output logic            tx_valid,

    // checker report
    output prbs_status_t    status
);

    // loopback path
    // same word and pulse seen on the top ports
    prbs_word_t link_word;
    logic       link_valid;

    // pattern source
    prbs_gen prbs_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .inject_err(inject_err),
        .tx_word   (link_word),
        .tx_valid  (link_valid)
    );

    // receiver side
    // syncs by itself, no seed shared with the generator
    prbs_check prbs_check_inst (
        .clk     (clk),
        .rst     (rst),
        .rx_word (link_word),
        .rx_valid(link_valid),
        .status  (status)
    );

    // tap of the link
    assign tx_word  = link_word;
    assign tx_valid = link_valid;

endmodule

`default_nettype wire

//--- test/prbs_monitor.sv
// checks every DUT port against a bit-serial PRBS31 model each rising edge; assumes the hunt words before a lock are clean
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module prbs_monitor
    import prbs_pkg::*;
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          enable,
    input  wire logic          inject_err,
    input  wire prbs_word_t    tx_word,
    input  wire logic          tx_valid,
    input  wire prbs_status_t  status,
    // test bookkeeping from the stimulus side
    input  wire logic [31:0]   test_id,
    input  wire logic          test_end,
    input  wire logic [31:0]   stim_errors,
    output wire logic [31:0]   checks,
    output wire logic [31:0]   errors
);

    // 32 bit hunt history fills after this many words
    localparam int HUNT_WORDS = 32 / `PRBS_DATA_W;
    localparam int CNT_MAX    = (1 << `PRBS_CNT_W) - 1;

    // generator model, bit j is the bit sent j+1 steps ago
    logic [`PRBS_LFSR_W-1:0] gen_hist;
    logic [`PRBS_LFSR_W:0]   step;
    prbs_word_t              raw_bits;
    prbs_word_t              exp_word;
    prbs_word_t              exp_clean;
    logic                    exp_valid;

    // checker model
    logic m_locked;
    logic exp_bit_err;
    int   hunt_n;
    int   bad_run;
    int   exp_cnt;
    int   nerr;

    // nothing is compared before the first reset edge
    logic armed       = 1'b0;
    int   n_checks    = 0;
    int   n_errors    = 0;
    int   checks_base = 0;
    int   errors_base = 0;

    assign checks = n_checks;
    assign errors = n_errors;

    // one step of x^31 + x^28 + 1, b[n] = b[n-31] ^ b[n-28]
    // returns the new bit on top of the next history
    function automatic logic [`PRBS_LFSR_W:0] prbs_bit(input logic [`PRBS_LFSR_W-1:0] hist);
        logic b;
        b = hist[30] ^ hist[27];
        return {b, hist[`PRBS_LFSR_W-2:0], b};
    endfunction

    function automatic string test_name(input logic [31:0] id);
        case (id)
            1: return "sequence";
            2: return "lock";
            3: return "error count";
            4: return "unlock and relock";
            5: return "reset";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    always @(posedge clk) begin
        // pre-edge values, registered one edge back
        if (armed) begin
            check_value("tx_valid", 32'(tx_valid), 32'(exp_valid));
            if (exp_valid) begin
                check_value("tx_word", 32'(tx_word), 32'(exp_word));
            end
            check_value("status.locked", 32'(status.locked), 32'(m_locked));
            check_value("status.bit_err", 32'(status.bit_err), 32'(exp_bit_err));
            check_value("status.err_count", 32'(status.err_count),
                        (exp_cnt > CNT_MAX) ? CNT_MAX : exp_cnt);
        end
        if (rst) begin
            armed       = 1'b1;
            gen_hist    = '1;
            exp_valid   = 1'b0;
            m_locked    = 1'b0;
            exp_bit_err = 1'b0;
            hunt_n      = 0;
            bad_run     = 0;
            exp_cnt     = 0;
        end else begin
            exp_bit_err = 1'b0;
            // checker takes the word now on the link
            if (exp_valid) begin
                nerr = $countones(exp_word ^ exp_clean);
                if (!m_locked) begin
                    hunt_n++;
                    if (hunt_n == HUNT_WORDS) begin
                        m_locked = 1'b1;
                        hunt_n   = 0;
                        bad_run  = 0;
                    end
                end else begin
                    exp_cnt += nerr;
                    if (nerr == 0) begin
                        bad_run = 0;
                    end else begin
                        bad_run++;
                        // the word that drops lock gives no pulse
                        if (bad_run == `PRBS_UNLOCK_N) begin
                            m_locked = 1'b0;
                            bad_run  = 0;
                        end else begin
                            exp_bit_err = 1'b1;
                        end
                    end
                end
            end
            // generator makes the next word, msb first
            exp_valid = enable;
            if (enable) begin
                for (int i = 0; i < `PRBS_DATA_W; i++) begin
                    step     = prbs_bit(gen_hist);
                    gen_hist = step[`PRBS_LFSR_W-1:0];
                    raw_bits = {raw_bits[`PRBS_DATA_W-2:0], step[`PRBS_LFSR_W]};
                end
                exp_clean = ~raw_bits;
                exp_word  = exp_clean ^ {{(`PRBS_DATA_W-1){1'b0}}, inject_err};
            end
        end
        if (test_end) begin
            $display("test %0d %s: %0d checks, %0d errors", test_id, test_name(test_id),
                     n_checks - checks_base, n_errors + stim_errors - errors_base);
            checks_base = n_checks;
            errors_base = n_errors + stim_errors;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_prbs_loopback.sv
// five directed tests with LFSR-driven gaps; inputs change on the falling edge, port checks live in prbs_monitor
`timescale 1ns/1ps
`default_nettype none

`include "prbs_defs.svh"

module tb_prbs_loopback
    import prbs_pkg::*;
();

    localparam int CNT_W           = `PRBS_CNT_W;
    localparam int LOCK_WAIT       = 10;
    localparam int WORDS_TOTAL     = 48 + 12 + 24 + 8 + 14;
    // each word takes at most 4 cycles with its gap
    localparam int STIM_CYCLES     = WORDS_TOTAL * 4 + 3 * 5 + 3 * LOCK_WAIT + 5 * 4;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES * 2 + 200;

    logic         clk;
    logic         rst;
    logic         enable;
    logic         inject_err;
    prbs_word_t   tx_word;
    logic         tx_valid;
    prbs_status_t status;

    logic [31:0]      test_id;
    logic             test_end;
    logic [31:0]      checks;
    logic [31:0]      errors;
    int               stim_errors;
    logic [31:0]      rng;
    logic [CNT_W-1:0] cnt_before;
    int               n_inj;
    int               run;
    int               pick;
    logic             ok;

    prbs_loopback prbs_loopback_inst (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .inject_err(inject_err),
        .tx_word   (tx_word),
        .tx_valid  (tx_valid),
        .status    (status)
    );

    prbs_monitor prbs_monitor_inst (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .inject_err (inject_err),
        .tx_word    (tx_word),
        .tx_valid   (tx_valid),
        .status     (status),
        .test_id    (test_id),
        .test_end   (test_end),
        .stim_errors(stim_errors),
        .checks     (checks),
        .errors     (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v   = (v << 1) | int'(rng[0]);
            rng = lfsr_step(rng);
        end
    endtask

    // one enable cycle, then 0 to 3 idle cycles
    task automatic send_word(input logic inj);
        int g;
        enable     = 1'b1;
        inject_err = inj;
        @(negedge clk);
        enable     = 1'b0;
        inject_err = 1'b0;
        take_bits(2, g);
        repeat (g) @(negedge clk);
    endtask

    task automatic apply_reset();
        rst        = 1'b1;
        enable     = 1'b0;
        inject_err = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic wait_locked(input logic want, output logic hit);
        hit = 1'b0;
        for (int i = 0; i < LOCK_WAIT && !hit; i++) begin
            if (status.locked === want) begin
                hit = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // let the last word reach status
    task automatic drain();
        repeat (3) @(negedge clk);
    endtask

    task automatic expect_count(input logic [CNT_W-1:0] exp);
        if (status.err_count !== exp) begin
            stim_errors++;
            $display("MISMATCH status.err_count: got %h expected %h", status.err_count, exp);
        end
    endtask

    task automatic finish_test(input int id);
        test_id  = id;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        enable      = 1'b0;
        inject_err  = 1'b0;
        test_id     = 0;
        test_end    = 1'b0;
        stim_errors = 0;
        rng         = 32'hd93dbc8e;
        apply_reset();

        // random gaps, flips only once the checker holds lock, runs kept short
        run = 0;
        for (int i = 0; i < 48; i++) begin
            take_bits(2, pick);
            if (i >= 4 && pick == 3 && run < 2) begin
                run++;
                send_word(1'b1);
            end else begin
                run = 0;
                send_word(1'b0);
            end
        end
        drain();
        finish_test(1);

        // lock from hunt on clean words
        apply_reset();
        repeat (4) send_word(1'b0);
        wait_locked(1'b1, ok);
        if (!ok) begin
            stim_errors++;
            $display("checker did not lock within %0d cycles of the 4th clean word", LOCK_WAIT);
        end
        repeat (8) send_word(1'b0);
        drain();
        expect_count('0);
        finish_test(2);

        // isolated flips, one bit each
        cnt_before = status.err_count;
        n_inj      = 0;
        for (int i = 0; i < 24; i++) begin
            if (i % 3 == 1) begin
                n_inj++;
                send_word(1'b1);
            end else begin
                send_word(1'b0);
            end
        end
        drain();
        expect_count(CNT_W'(cnt_before + n_inj));
        finish_test(3);

        // a run of bad words drops lock, all of them still counted
        cnt_before = status.err_count;
        repeat (`PRBS_UNLOCK_N) send_word(1'b1);
        wait_locked(1'b0, ok);
        if (!ok) begin
            stim_errors++;
            $display("checker stayed locked after %0d bad words", `PRBS_UNLOCK_N);
        end
        repeat (4) send_word(1'b0);
        wait_locked(1'b1, ok);
        if (!ok) begin
            stim_errors++;
            $display("checker did not relock after 4 clean words");
        end
        drain();
        expect_count(CNT_W'(cnt_before + `PRBS_UNLOCK_N));
        finish_test(4);

        // reset lands while a word is on the link
        repeat (5) send_word(1'b0);
        enable = 1'b1;
        @(negedge clk);
        apply_reset();
        if (status.locked !== 1'b0) begin
            stim_errors++;
            $display("MISMATCH status.locked: got %h expected %h", status.locked, 1'b0);
        end
        expect_count('0);
        repeat (8) send_word(1'b0);
        drain();
        finish_test(5);

        $display("tests 5, checks %0d, errors %0d", checks, errors + stim_errors);
        if (errors + stim_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- prbs_loopback.f
+incdir+include
hw/prbs_pkg.sv
hw/lfsr_core.sv
hw/prbs_gen.sv
hw/prbs_check.sv
hw/prbs_loopback.sv
test/prbs_monitor.sv
test/tb_prbs_loopback.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_prbs_loopback
FILELIST  = prbs_loopback.f
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
